/* logic/adpll_pkg.sv */
`default_nettype none

package adpll_pkg;

    localparam int ACCUM_WIDTH = 12;                 // reference tuning word
    localparam int DCO_WIDTH   = 16;                 // 16x finer than the reference
    localparam int ERR_WIDTH   = 8;
    localparam int ERR_MAX     = 127;                // symmetric saturation

    // DCO word limits, 16 * k_val for a matching frequency
    localparam int K_NOM = 2048;
    localparam int K_MIN = 1024;
    localparam int K_MAX = 4096;

    // error is scaled up first, then the gains are right shifts
    localparam int ERR_SCALE = 8;
    localparam int KP_SHIFT  = 4;                    // kp = 16
    localparam int KI_SHIFT  = 7;                    // ki = 2

    localparam int INT_WIDTH   = 24;
    localparam int INT_LIM     = (K_MAX - K_MIN) << KI_SHIFT;   // integrator stop
    localparam int K_SUM_WIDTH = INT_WIDTH + 2;

    localparam int LOCK_TOL       = 2;               // cycles of error
    localparam int LOCK_COUNT     = 16;              // samples in a row
    localparam int LOCK_CNT_WIDTH = $clog2(LOCK_COUNT + 1);

    typedef struct packed {
        logic signed [ERR_WIDTH-1:0] error;          // positive when ref leads
        logic                        error_valid;
        logic                        lock;
    } loop_status_t;

endpackage

`default_nettype wire

/* logic/adpll_top.sv */
`timescale 1ns/1ps
`default_nettype none

module adpll_top (
    input  wire logic                                fpga_clk_i,
    input  wire logic                                arst_n_i,
    input  wire logic [adpll_pkg::ACCUM_WIDTH-1:0]   k_val_i,     // from the switches
    output logic                                     ref_o,
    output logic                                     gen_clk_o,
    output logic [adpll_pkg::ERR_WIDTH-1:0]          error_o,
    output logic                                     lock_o,
    output logic [display_pkg::DIGIT_LINES-1:0]      digit_o,
    output logic [display_pkg::SEG_WIDTH-1:0]        segment_o
);
    import adpll_pkg::*;
    import display_pkg::*;

    loop_status_t status;
    disp_drive_t  drive;

    phase_accum #(
        .WIDTH (ACCUM_WIDTH)
    ) reference_osc (
        .fpga_clk_i (fpga_clk_i),
        .arst_n_i   (arst_n_i),
        .enable_i   (1'b1),
        .k_val_i    (k_val_i),
        .clk_o      (ref_o)
    );

    ring_adpll adpll0 (
        .fpga_clk_i (fpga_clk_i),
        .arst_n_i   (arst_n_i),
        .ref_clk_i  (ref_o),
        .gen_clk_o  (gen_clk_o),
        .status_o   (status)
    );

    display_interface disp0 (
        .fpga_clk_i (fpga_clk_i),
        .arst_n_i   (arst_n_i),
        .value_i    (status.error),                  // signed error as sign and hex
        .drive_o    (drive)
    );

    assign error_o   = status.error;
    assign lock_o    = status.lock;
    assign digit_o   = drive.digit;
    assign segment_o = drive.segment;

endmodule

`default_nettype wire

/* logic/display_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module display_interface (
    input  wire logic                                      fpga_clk_i,
    input  wire logic                                      arst_n_i,
    input  wire logic signed [display_pkg::VALUE_WIDTH-1:0] value_i,
    output display_pkg::disp_drive_t                       drive_o
);
    import display_pkg::*;

    logic [DIV_WIDTH-1:0]   div_q;                   // cycles on the current digit
    logic [IDX_WIDTH-1:0]   idx_q;                   // digit being driven next
    logic [VALUE_WIDTH-1:0] mag;
    logic                   neg;
    logic [SEG_WIDTH-1:0]   seg_d;

    assign neg = value_i[VALUE_WIDTH-1];
    assign mag = neg ? -value_i : value_i;           // -128 reads as 0x80

    always_comb begin
        case (idx_q)
            IDX_WIDTH'(0): seg_d = SEG_HEX[mag[3:0]];
            IDX_WIDTH'(1): seg_d = SEG_HEX[mag[7:4]];
            IDX_WIDTH'(2): seg_d = neg ? SEG_MINUS : SEG_BLANK;
            default:       seg_d = SEG_BLANK;        // leftmost digit unused
        endcase
    end

    always_ff @(posedge fpga_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q           <= '0;
            idx_q           <= '0;
            drive_o.digit   <= DIGIT_OFF;
            drive_o.segment <= SEG_BLANK;
        end else begin
            drive_o.digit   <= ~(DIGIT_LINES'(1) << idx_q);
            drive_o.segment <= seg_d;
            if (div_q == DIV_WIDTH'(SCAN_DIV - 1)) begin
                div_q <= '0;
                if (idx_q == IDX_WIDTH'(DIGITS - 1)) begin
                    idx_q <= '0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    // first drive is loaded on the edge after release
    a_digit_onehot: assert property (
        @(posedge fpga_clk_i) disable iff (!arst_n_i)
        $past(arst_n_i) |-> $onehot(~drive_o.digit)
    );

endmodule

`default_nettype wire

/* logic/display_pkg.sv */
`default_nettype none

package display_pkg;

    localparam int DIGITS      = 4;
    localparam int SCAN_DIV    = 4;                  // cycles per digit
    localparam int IDX_WIDTH   = $clog2(DIGITS);
    localparam int DIV_WIDTH   = $clog2(SCAN_DIV);
    localparam int DIGIT_LINES = 8;                  // board has eight digit lines
    localparam int SEG_WIDTH   = 8;                  // {dp, g, f, e, d, c, b, a}
    localparam int VALUE_WIDTH = 8;

    localparam logic [DIGIT_LINES-1:0] DIGIT_OFF = '1;   // active low
    localparam logic [SEG_WIDTH-1:0]   SEG_MINUS = 8'hBF;
    localparam logic [SEG_WIDTH-1:0]   SEG_BLANK = 8'hFF;

    // active-low hex font, index 15 first
    localparam logic [15:0][SEG_WIDTH-1:0] SEG_HEX = {
        8'h8E, 8'h86, 8'hA1, 8'hC6,                  // F E d C
        8'h83, 8'h88, 8'h90, 8'h80,                  // b A 9 8
        8'hF8, 8'h82, 8'h92, 8'h99,                  // 7 6 5 4
        8'hB0, 8'hA4, 8'hF9, 8'hC0                   // 3 2 1 0
    };

    typedef struct packed {
        logic [DIGIT_LINES-1:0] digit;               // one line low at a time
        logic [SEG_WIDTH-1:0]   segment;
    } disp_drive_t;

endpackage

`default_nettype wire

/* logic/loop_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_filter (
    input  wire logic                                  fpga_clk_i,
    input  wire logic                                  arst_n_i,
    input  wire logic signed [adpll_pkg::ERR_WIDTH-1:0] error_i,
    input  wire logic                                  error_valid_i,
    output logic [adpll_pkg::DCO_WIDTH-1:0]            k_dco_o,
    output logic                                       lock_o
);
    import adpll_pkg::*;

    logic signed [INT_WIDTH-1:0]   err_scaled;
    logic signed [INT_WIDTH-1:0]   err_hold_q;       // last sample for the P path
    logic signed [INT_WIDTH-1:0]   integ_q;
    logic signed [INT_WIDTH:0]     integ_sum;
    logic signed [K_SUM_WIDTH-1:0] i_term;
    logic signed [K_SUM_WIDTH-1:0] p_term;
    logic signed [K_SUM_WIDTH-1:0] k_sum;
    logic                          upd_q;
    logic                          in_tol;
    logic [LOCK_CNT_WIDTH-1:0]     lock_cnt_q;

    assign err_scaled = {{(INT_WIDTH-ERR_WIDTH){error_i[ERR_WIDTH-1]}}, error_i} <<< ERR_SCALE;
    assign integ_sum  = integ_q + err_scaled;

    assign i_term   = integ_q >>> KI_SHIFT;
    assign p_term   = err_hold_q >>> KP_SHIFT;
    assign k_sum    = K_SUM_WIDTH'(K_NOM) + i_term + p_term;

    assign in_tol = (error_i >= -LOCK_TOL) && (error_i <= LOCK_TOL);

    always_ff @(posedge fpga_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_hold_q <= '0;
            integ_q    <= '0;
            upd_q      <= 1'b0;
            k_dco_o    <= DCO_WIDTH'(K_NOM);
            lock_cnt_q <= '0;
            lock_o     <= 1'b0;
        end else begin
            upd_q <= error_valid_i;
            if (error_valid_i) begin
                err_hold_q <= err_scaled;
                if (integ_sum > INT_LIM) begin
                    integ_q <= INT_WIDTH'(INT_LIM);   // no windup past the clamp range
                end else if (integ_sum < -INT_LIM) begin
                    integ_q <= INT_WIDTH'(-INT_LIM);
                end else begin
                    integ_q <= integ_sum[INT_WIDTH-1:0];
                end
                if (in_tol) begin
                    if (lock_cnt_q == LOCK_CNT_WIDTH'(LOCK_COUNT - 1)) begin
                        lock_o <= 1'b1;
                    end
                    if (lock_cnt_q != LOCK_CNT_WIDTH'(LOCK_COUNT)) begin
                        lock_cnt_q <= lock_cnt_q + 1'b1;
                    end
                end else begin
                    lock_cnt_q <= '0;                // first miss drops lock
                    lock_o     <= 1'b0;
                end
            end
            if (upd_q) begin
                if (k_sum < K_MIN) begin
                    k_dco_o <= DCO_WIDTH'(K_MIN);
                end else if (k_sum > K_MAX) begin
                    k_dco_o <= DCO_WIDTH'(K_MAX);
                end else begin
                    k_dco_o <= k_sum[DCO_WIDTH-1:0];
                end
            end
        end
    end

    a_k_in_range: assert property (
        @(posedge fpga_clk_i) disable iff (!arst_n_i)
        (k_dco_o >= K_MIN) && (k_dco_o <= K_MAX)
    );

endmodule

`default_nettype wire

/* logic/phase_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_accum #(
    parameter int WIDTH = 12
) (
    input  wire logic             fpga_clk_i,
    input  wire logic             arst_n_i,
    input  wire logic             enable_i,
    input  wire logic [WIDTH-1:0] k_val_i,
    output logic                  clk_o
);

    logic [WIDTH-1:0] acc_q;                         // wraps, so f = k / 2**WIDTH

    always_ff @(posedge fpga_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q <= '0;
            clk_o <= 1'b0;
        end else begin
            if (enable_i) begin
                acc_q <= acc_q + k_val_i;
            end
            clk_o <= acc_q[WIDTH-1];                 // one cycle behind the add
        end
    end

    // low in reset and on the first output after release
    a_clk_low_in_reset: assert property (
        @(posedge fpga_clk_i) !$past(arst_n_i, 2) |-> !clk_o
    );

endmodule

`default_nettype wire

/* logic/phase_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_detector (
    input  wire logic                                  fpga_clk_i,
    input  wire logic                                  arst_n_i,
    input  wire logic                                  ref_clk_i,
    input  wire logic                                  gen_clk_i,
    output logic signed [adpll_pkg::ERR_WIDTH-1:0]     error_o,
    output logic                                       error_valid_o
);
    import adpll_pkg::*;

    logic                        ref_q;
    logic                        gen_q;
    logic                        ref_rise;
    logic                        gen_rise;
    logic                        active_q;           // measurement open
    logic                        ref_lead_q;         // ref edge opened it
    logic                        close_edge;
    logic signed [ERR_WIDTH-1:0] cnt_q;

    assign ref_rise   = ref_clk_i & ~ref_q;
    assign gen_rise   = gen_clk_i & ~gen_q;
    assign close_edge = ref_lead_q ? gen_rise : ref_rise;   // edge of the other clock

    always_ff @(posedge fpga_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ref_q         <= 1'b0;
            gen_q         <= 1'b0;
            active_q      <= 1'b0;
            ref_lead_q    <= 1'b0;
            cnt_q         <= '0;
            error_o       <= '0;
            error_valid_o <= 1'b0;
        end else begin
            ref_q         <= ref_clk_i;
            gen_q         <= gen_clk_i;
            error_valid_o <= 1'b0;
            if (!active_q) begin
                if (ref_rise && gen_rise) begin
                    error_o       <= '0;             // coincident edges
                    error_valid_o <= 1'b1;
                end else if (ref_rise || gen_rise) begin
                    active_q   <= 1'b1;
                    ref_lead_q <= ref_rise;
                    cnt_q      <= ref_rise ? ERR_WIDTH'(1) : -ERR_WIDTH'(1);
                end
            end else if (close_edge) begin
                error_o       <= cnt_q;
                error_valid_o <= 1'b1;
                active_q      <= 1'b0;
            end else if (ref_lead_q) begin
                if (cnt_q != ERR_MAX) begin
                    cnt_q <= cnt_q + ERR_WIDTH'(1);  // gen lagging
                end
            end else begin
                if (cnt_q != -ERR_MAX) begin
                    cnt_q <= cnt_q - ERR_WIDTH'(1);  // gen leading
                end
            end
        end
    end

    a_valid_single: assert property (
        @(posedge fpga_clk_i) disable iff (!arst_n_i)
        error_valid_o |=> !error_valid_o
    );

    a_error_range: assert property (
        @(posedge fpga_clk_i) disable iff (!arst_n_i)
        (error_o >= -ERR_MAX) && (error_o <= ERR_MAX)
    );

endmodule

`default_nettype wire

/* logic/ring_adpll.sv */
`timescale 1ns/1ps
`default_nettype none

module ring_adpll (
    input  wire logic             fpga_clk_i,
    input  wire logic             arst_n_i,
    input  wire logic             ref_clk_i,
    output logic                  gen_clk_o,
    output adpll_pkg::loop_status_t status_o
);
    import adpll_pkg::*;

    logic signed [ERR_WIDTH-1:0] error;
    logic                        error_valid;
    logic [DCO_WIDTH-1:0]        k_dco;
    logic                        lock;

    phase_detector det0 (
        .fpga_clk_i    (fpga_clk_i),
        .arst_n_i      (arst_n_i),
        .ref_clk_i     (ref_clk_i),
        .gen_clk_i     (gen_clk_o),                  // feedback from the DCO
        .error_o       (error),
        .error_valid_o (error_valid)
    );

    loop_filter filt0 (
        .fpga_clk_i    (fpga_clk_i),
        .arst_n_i      (arst_n_i),
        .error_i       (error),
        .error_valid_i (error_valid),
        .k_dco_o       (k_dco),
        .lock_o        (lock)
    );

    // accumulator stands in for the ring oscillator
    phase_accum #(
        .WIDTH (DCO_WIDTH)
    ) dco0 (
        .fpga_clk_i (fpga_clk_i),
        .arst_n_i   (arst_n_i),
        .enable_i   (1'b1),
        .k_val_i    (k_dco),
        .clk_o      (gen_clk_o)
    );

    assign status_o = '{error: error, error_valid: error_valid, lock: lock};

    // lock can only move on the cycle after a detector sample
    a_lock_after_sample: assert property (
        @(posedge fpga_clk_i) disable iff (!arst_n_i)
        $rose(lock) |-> $past(error_valid)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the ADPLL testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module adpll_tb --Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vadpll_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

/* verif/adpll_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module adpll_tb;
    import adpll_pkg::*;
    import display_pkg::*;

    localparam int CLK_HALF       = 4;               // 8 ns period
    localparam int RESET_CYCLES   = 10;
    localparam int REF_SEGS       = 4;
    localparam int REF_CYCLES     = 300;
    localparam int LOCK_RUNS      = 3;
    localparam int DROP_WINDOW    = 4000;            // old lock has to fall first
    localparam int LOCK_WINDOW    = 30000;
    localparam int COUNT_WINDOW   = 1024;
    localparam int DISP_CYCLES    = 64;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + REF_SEGS * REF_CYCLES
        + LOCK_RUNS * (DROP_WINDOW + LOCK_WINDOW + COUNT_WINDOW) + DISP_CYCLES + 2000;

    logic                   fpga_clk;
    logic                   arst_n;
    logic [ACCUM_WIDTH-1:0] k_val;
    logic                   ref_clk;
    logic                   gen_clk;
    logic [ERR_WIDTH-1:0]   error_val;
    logic                   lock;
    logic [7:0]             digit;
    logic [7:0]             segment;

    logic [31:0]            lcg_state;
    logic [ACCUM_WIDTH-1:0] m_acc;                   // reference accumulator copy
    logic                   m_ref;
    logic                   released;
    logic                   ref_last;
    logic                   gen_last;
    int                     rel_cycles;              // negedges since reset release
    int                     err_last;
    int                     err_last2;
    int                     ref_edges;
    int                     gen_edges;
    int                     checks;
    int                     cycle_cnt;
    int                     test_errs [1:5];

    adpll_top dut0 (
        .fpga_clk_i (fpga_clk),
        .arst_n_i   (arst_n),
        .k_val_i    (k_val),
        .ref_o      (ref_clk),
        .gen_clk_o  (gen_clk),
        .error_o    (error_val),
        .lock_o     (lock),
        .digit_o    (digit),
        .segment_o  (segment)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // active-low seven-segment font
    function automatic logic [7:0] hex_font(input logic [3:0] h);
        case (h)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    task automatic check_value(input int test_id, input string what,
                               input logic [31:0] got, input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            test_errs[test_id]++;
            $display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic rand_k(input int lo, input int span, output logic [ACCUM_WIDTH-1:0] k);
        lcg_state = lcg_next(lcg_state);
        k = ACCUM_WIDTH'(lo + (lcg_state[31:16] % span));   // upper bits are less regular
    endtask

    // one clock, with the checks that run all the time
    task automatic step();
        int         err;
        int         mag;
        int         idx;
        logic [7:0] exp_seg;
        logic [7:0] exp_digit;
        @(negedge fpga_clk);
        err = int'($signed(error_val));
        check_value(4, "error_o within +-127", 32'(err >= -127 && err <= 127), 32'd1);
        if (released) begin
            rel_cycles++;
            m_ref = m_acc[ACCUM_WIDTH-1];            // msb before this add
            m_acc = m_acc + k_val;
            check_value(2, "ref_o against accumulator model", 32'(ref_clk), 32'(m_ref));
            if (lock && err_last != err_last2) begin
                check_value(4, "error magnitude while locked",
                            32'(err_last >= -LOCK_TOL && err_last <= LOCK_TOL), 32'd1);
            end
            idx = ((rel_cycles - 1) / SCAN_DIV) % DIGITS;
            mag = (err_last < 0) ? -err_last : err_last;
            case (idx)
                0: exp_seg = hex_font(mag[3:0]);
                1: exp_seg = hex_font(mag[7:4]);
                2: exp_seg = (err_last < 0) ? SEG_MINUS : SEG_BLANK;
                default: exp_seg = SEG_BLANK;
            endcase
            exp_digit = ~(8'd1 << idx);
            check_value(5, "one digit line low", 32'($countones(~digit)), 32'd1);
            check_value(5, "digit_o scan position", 32'(digit), 32'(exp_digit));
            check_value(5, "segment_o decode", 32'(segment), 32'(exp_seg));
            if (ref_clk && !ref_last) begin
                ref_edges++;
            end
            if (gen_clk && !gen_last) begin
                gen_edges++;
            end
        end
        err_last2 = err_last;
        err_last  = err;
        ref_last  = ref_clk;
        gen_last  = gen_clk;
    endtask

    initial begin : clock_gen
        fpga_clk = 1'b0;
        forever begin
            #CLK_HALF;
            fpga_clk = ~fpga_clk;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge fpga_clk);
            cycle_cnt++;
        end
        $display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        logic [ACCUM_WIDTH-1:0] k_new;
        int                     waited;
        int                     diff;
        int                     total;
        arst_n     = 1'b0;
        k_val      = ACCUM_WIDTH'(128);
        lcg_state  = 32'h2c0b_017c;
        m_acc      = '0;
        m_ref      = 1'b0;
        released   = 1'b0;
        ref_last   = 1'b0;
        gen_last   = 1'b0;
        rel_cycles = 0;
        err_last   = 0;
        err_last2  = 0;
        ref_edges  = 0;
        gen_edges  = 0;
        checks     = 0;
        foreach (test_errs[i]) begin
            test_errs[i] = 0;
        end

        repeat (RESET_CYCLES) begin
            step();
            check_value(1, "digit_o in reset", 32'(digit), 32'hFF);
            check_value(1, "segment_o in reset", 32'(segment), 32'(SEG_BLANK));
            check_value(1, "lock_o in reset", 32'(lock), 32'd0);
            check_value(1, "ref_o in reset", 32'(ref_clk), 32'd0);
            check_value(1, "gen_clk_o in reset", 32'(gen_clk), 32'd0);
        end
        arst_n   = 1'b1;                             // released on a falling edge
        released = 1'b1;
        $display("test 1 reset state: %0d errors", test_errs[1]);

        for (int s = 0; s < REF_SEGS; s++) begin
            rand_k(96, 129, k_new);
            k_val = k_new;
            repeat (REF_CYCLES) step();
        end
        $display("test 2 reference oscillator: %0d errors", test_errs[2]);

        for (int r = 0; r < LOCK_RUNS; r++) begin
            rand_k((r % 2 == 0) ? 96 : 180, 45, k_new);   // alternate low and high band
            k_val  = k_new;
            waited = 0;
            while (lock && waited < DROP_WINDOW) begin
                step();
                waited++;
            end
            waited = 0;
            while (!lock && waited < LOCK_WINDOW) begin
                step();
                waited++;
            end
            if (!lock) begin
                test_errs[3]++;
                $display("lock_o did not rise within %0d cycles for k_val_i = %0d",
                         LOCK_WINDOW, k_new);
            end else begin
                ref_edges = 0;
                gen_edges = 0;
                repeat (COUNT_WINDOW) step();
                diff = ref_edges - gen_edges;
                check_value(3, "ref and gen edge counts within one",
                            32'(diff >= -1 && diff <= 1), 32'd1);
            end
        end
        $display("test 3 lock: %0d errors", test_errs[3]);

        repeat (DISP_CYCLES) step();
        $display("test 4 error bounds: %0d errors", test_errs[4]);
        $display("test 5 display scan: %0d errors", test_errs[5]);

        total = 0;
        foreach (test_errs[i]) begin
            total += test_errs[i];
        end
        $display("%0d checks, %0d errors", checks, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/adpll_pkg.sv
logic/display_pkg.sv
logic/phase_accum.sv
logic/phase_detector.sv
logic/loop_filter.sv
logic/ring_adpll.sv
logic/display_interface.sv
logic/adpll_top.sv
verif/adpll_tb.sv
